// File: Makefile
# Verilator build and run of the DMA front end testbench

VERILATOR ?= verilator
TOP       ?= tb_cluster_dma_frontend
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f project.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/cluster_cfg_pkg.sv
/*
 * Cluster configuration package
 * Address, length and counter widths, their vector types, cluster size defaults
 */
package cluster_cfg_pkg;

  // Widths with a meaning of their own
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth  = 16;
  localparam int unsigned CntWidth  = 16;

  // Byte address
  typedef logic [AddrWidth-1:0] addr_t;

  // Byte count of a burst or of one chunk
  typedef logic [LenWidth-1:0] len_t;

  // Outstanding chunk counter
  typedef logic [CntWidth-1:0] cnt_t;

  // Cluster size defaults for the top level
  localparam int unsigned DefNumGroups        = 4;
  localparam int unsigned DefNumBanksPerGroup = 16;

  // Bytes per bank word, one interleave step
  localparam int unsigned BankBytes = 4;

endpackage : cluster_cfg_pkg

// File: hdl/cluster_dma_frontend.sv
/*
 * Cluster DMA front end
 * Input register, splitter, distributor, per-group registers and tracker
 */
`timescale 1ns/1ps

module cluster_dma_frontend #(
  parameter int unsigned NumGroups        = cluster_cfg_pkg::DefNumGroups,
  parameter int unsigned NumBanksPerGroup = cluster_cfg_pkg::DefNumBanksPerGroup
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Burst request
  input  dma_pkg::dma_req_t                 dma_req_i,
  input  logic                              dma_req_valid_i,
  output logic                              dma_req_ready_o,
  // Per-group chunk ports
  output dma_pkg::dma_req_t [NumGroups-1:0] group_req_o,
  output logic              [NumGroups-1:0] group_req_valid_o,
  input  logic              [NumGroups-1:0] group_req_ready_i,
  input  logic              [NumGroups-1:0] group_done_i,
  // Status
  output dma_pkg::dma_meta_t                dma_meta_o
);

  dma_pkg::dma_req_t                 req_cut;
  logic                              req_cut_valid;
  logic                              req_cut_ready;
  dma_pkg::dma_req_t                 chunk;
  logic                              chunk_valid;
  logic                              chunk_ready;
  logic                              chunk_issued;
  dma_pkg::dma_req_t [NumGroups-1:0] dist_req;
  logic              [NumGroups-1:0] dist_valid;
  logic              [NumGroups-1:0] dist_ready;

  dma_spill_reg i_req_reg (
    .clk_i   (clk_i          ),
    .arst_n_i(arst_n_i       ),
    .data_i  (dma_req_i      ),
    .valid_i (dma_req_valid_i),
    .ready_o (dma_req_ready_o),
    .data_o  (req_cut        ),
    .valid_o (req_cut_valid  ),
    .ready_i (req_cut_ready  )
  );

  dma_burst_splitter #(
    .NumGroups       (NumGroups       ),
    .NumBanksPerGroup(NumBanksPerGroup)
  ) i_splitter (
    .clk_i         (clk_i        ),
    .arst_n_i      (arst_n_i     ),
    .req_i         (req_cut      ),
    .req_valid_i   (req_cut_valid),
    .req_ready_o   (req_cut_ready),
    .chunk_o       (chunk        ),
    .chunk_valid_o (chunk_valid  ),
    .chunk_ready_i (chunk_ready  ),
    .chunk_issued_o(chunk_issued )
  );

  dma_group_distributor #(
    .NumGroups       (NumGroups       ),
    .NumBanksPerGroup(NumBanksPerGroup)
  ) i_distributor (
    .chunk_i      (chunk      ),
    .chunk_valid_i(chunk_valid),
    .chunk_ready_o(chunk_ready),
    .group_req_o  (dist_req   ),
    .group_valid_o(dist_valid ),
    .group_ready_i(dist_ready )
  );

  // One decoupling register per group port
  for (genvar g = 0; g < NumGroups; g++) begin : gen_group_reg
    dma_spill_reg i_group_reg (
      .clk_i   (clk_i               ),
      .arst_n_i(arst_n_i            ),
      .data_i  (dist_req[g]         ),
      .valid_i (dist_valid[g]       ),
      .ready_o (dist_ready[g]       ),
      .data_o  (group_req_o[g]      ),
      .valid_o (group_req_valid_o[g]),
      .ready_i (group_req_ready_i[g])
    );
  end : gen_group_reg

  dma_progress_tracker #(
    .NumGroups(NumGroups)
  ) i_tracker (
    .clk_i         (clk_i       ),
    .arst_n_i      (arst_n_i    ),
    .chunk_issued_i(chunk_issued),
    .group_done_i  (group_done_i),
    .dma_meta_o    (dma_meta_o  )
  );

endmodule : cluster_dma_frontend

// File: hdl/dma_burst_splitter.sv
/*
 * Burst splitter
 * Cuts one DMA burst into chunks that stay inside one destination block
 */
`timescale 1ns/1ps

module dma_burst_splitter #(
  parameter int unsigned NumGroups,
  parameter int unsigned NumBanksPerGroup
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::dma_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output dma_pkg::dma_req_t chunk_o,
  output logic              chunk_valid_o,
  input  logic              chunk_ready_i,
  output logic              chunk_issued_o
);

  localparam int unsigned BlockBytes = NumBanksPerGroup * cluster_cfg_pkg::BankBytes;

  dma_pkg::split_state_e  state_d, state_q;
  cluster_cfg_pkg::addr_t src_d, src_q;
  cluster_cfg_pkg::addr_t dst_d, dst_q;
  cluster_cfg_pkg::len_t  rem_d, rem_q;
  cluster_cfg_pkg::len_t  room;
  cluster_cfg_pkg::len_t  chunk_len;
  logic                   handshake;

  // Bytes left up to the next block boundary
  assign room = cluster_cfg_pkg::len_t'(BlockBytes)
              - cluster_cfg_pkg::len_t'(dst_q % BlockBytes);

  assign chunk_len      = (rem_q < room) ? rem_q : room;
  assign chunk_o        = '{src_addr: src_q, dst_addr: dst_q, num_bytes: chunk_len};
  assign chunk_valid_o  = (state_q == dma_pkg::SPLIT_BUSY);
  assign req_ready_o    = (state_q == dma_pkg::SPLIT_IDLE);
  assign handshake      = chunk_valid_o && chunk_ready_i;
  assign chunk_issued_o = handshake;

  always_comb begin
    state_d = state_q;
    src_d   = src_q;
    dst_d   = dst_q;
    rem_d   = rem_q;
    case (state_q)
      dma_pkg::SPLIT_IDLE: begin
        if (req_valid_i) begin
          src_d = req_i.src_addr;
          dst_d = req_i.dst_addr;
          rem_d = req_i.num_bytes;
          // empty bursts are swallowed here
          if (req_i.num_bytes != '0) begin
            state_d = dma_pkg::SPLIT_BUSY;
          end
        end
      end
      dma_pkg::SPLIT_BUSY: begin
        if (handshake) begin
          src_d = src_q + cluster_cfg_pkg::addr_t'(chunk_len);
          dst_d = dst_q + cluster_cfg_pkg::addr_t'(chunk_len);
          rem_d = rem_q - chunk_len;
          if (rem_q == chunk_len) begin
            state_d = dma_pkg::SPLIT_IDLE;
          end
        end
      end
      default: begin
        state_d = dma_pkg::SPLIT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= dma_pkg::SPLIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    src_q <= src_d;
    dst_q <= dst_d;
    rem_q <= rem_d;
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    chunk_valid_o |-> chunk_o.num_bytes != '0);

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    chunk_valid_o |-> (chunk_o.dst_addr % BlockBytes) + chunk_o.num_bytes <= BlockBytes);

endmodule : dma_burst_splitter

// File: hdl/dma_group_distributor.sv
/*
 * Group distributor
 * Steers each chunk to the group that owns its destination block
 */
`timescale 1ns/1ps

module dma_group_distributor #(
  parameter int unsigned NumGroups,
  parameter int unsigned NumBanksPerGroup
) (
  input  dma_pkg::dma_req_t                 chunk_i,
  input  logic                              chunk_valid_i,
  output logic                              chunk_ready_o,
  output dma_pkg::dma_req_t [NumGroups-1:0] group_req_o,
  output logic              [NumGroups-1:0] group_valid_o,
  input  logic              [NumGroups-1:0] group_ready_i
);

  localparam int unsigned BlockBytes = NumBanksPerGroup * cluster_cfg_pkg::BankBytes;
  localparam int unsigned GroupIdxW  = (NumGroups > 1) ? $clog2(NumGroups) : 1;

  logic [GroupIdxW-1:0] group_idx;

  // Blocks are interleaved over the groups
  assign group_idx = GroupIdxW'((chunk_i.dst_addr / BlockBytes) % NumGroups);

  // Payload goes everywhere, valid only to the owner
  for (genvar g = 0; g < NumGroups; g++) begin : gen_group_req
    assign group_req_o[g] = chunk_i;
  end : gen_group_req

  always_comb begin
    group_valid_o            = '0;
    group_valid_o[group_idx] = chunk_valid_i;
  end

  assign chunk_ready_o = group_ready_i[group_idx];

  always_comb begin
    assert #0 ($onehot0(group_valid_o));
  end

endmodule : dma_group_distributor

// File: hdl/dma_pkg.sv
/*
 * DMA package
 * Burst request and status structs, burst splitter state encoding
 */
package dma_pkg;

  // One burst request or one chunk of it
  typedef struct packed {
    cluster_cfg_pkg::addr_t src_addr;
    cluster_cfg_pkg::addr_t dst_addr;
    cluster_cfg_pkg::len_t  num_bytes;
  } dma_req_t;

  // Status word towards the requester
  typedef struct packed {
    logic busy;
    logic trans_complete;
  } dma_meta_t;

  // Splitter FSM
  typedef enum logic {
    SPLIT_IDLE = 1'b0,
    SPLIT_BUSY = 1'b1
  } split_state_e;

endpackage : dma_pkg

// File: hdl/dma_progress_tracker.sv
/*
 * Progress tracker
 * Outstanding chunk count and registered busy/complete status
 */
`timescale 1ns/1ps

module dma_progress_tracker #(
  parameter int unsigned NumGroups
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 chunk_issued_i,
  input  logic [NumGroups-1:0] group_done_i,
  output dma_pkg::dma_meta_t   dma_meta_o
);

  cluster_cfg_pkg::cnt_t count_d, count_q;
  cluster_cfg_pkg::cnt_t done_cnt;
  dma_pkg::dma_meta_t    meta_d;

  // Several groups may finish in the same cycle
  always_comb begin
    done_cnt = '0;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      done_cnt = done_cnt + cluster_cfg_pkg::cnt_t'(group_done_i[g]);
    end
    count_d = count_q + cluster_cfg_pkg::cnt_t'(chunk_issued_i) - done_cnt;
  end

  always_comb begin
    meta_d.busy           = (count_d != '0);
    // pulse once when the last outstanding chunk drains
    meta_d.trans_complete = (count_q != '0) && (count_d == '0);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q    <= '0;
      dma_meta_o <= '0;
    end else begin
      count_q    <= count_d;
      dma_meta_o <= meta_d;
    end
  end

  // Groups never report more chunks than were handed out
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_cnt <= count_q);

endmodule : dma_progress_tracker

// File: hdl/dma_spill_reg.sv
/*
 * Two-slot spill register for a DMA request channel
 */
`timescale 1ns/1ps

module dma_spill_reg (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::dma_req_t data_i,
  input  logic              valid_i,
  output logic              ready_o,
  output dma_pkg::dma_req_t data_o,
  output logic              valid_o,
  input  logic              ready_i
);

  dma_pkg::dma_req_t a_data_q;
  dma_pkg::dma_req_t b_data_q;
  logic              a_full_q;
  logic              b_full_q;
  logic              a_fill;
  logic              a_drain;
  logic              b_fill;
  logic              b_drain;

  // Slot A takes the input, slot B catches A's item when the sink stalls
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Both directions come from flops only
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  // B always holds the older item
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  // Stalled output keeps its item
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule : dma_spill_reg

// File: project.f
hdl/cluster_cfg_pkg.sv
hdl/dma_pkg.sv
hdl/dma_spill_reg.sv
hdl/dma_burst_splitter.sv
hdl/dma_group_distributor.sv
hdl/dma_progress_tracker.sv
hdl/cluster_dma_frontend.sv
tests/tb_cluster_dma_frontend.sv

// File: tests/dma_trace.txt
# T name ready_mode(0 always, 1 random) | R src dst len | C group src dst len
# Values in hex except group and mode; blocks of 64 bytes over 4 groups
T single 0
R 1000 0010 0020
C 0 1000 0010 0020
R 2000 00c4 0008
C 3 2000 00c4 0008
T split 0
R 3000 0130 00b0
C 0 3000 0130 0010
C 1 3010 0140 0040
C 2 3050 0180 0040
C 3 3090 01c0 0020
T backpressure 1
R 4000 0208 0100
C 0 4000 0208 0038
C 1 4038 0240 0040
C 2 4078 0280 0040
C 3 40b8 02c0 0040
C 0 40f8 0300 0008
T back_to_back 1
R 5000 0400 0050
R 6000 07f0 0020
R 7000 0044 000c
C 0 5000 0400 0040
C 1 5040 0440 0010
C 3 6000 07f0 0010
C 0 6010 0800 0010
C 1 7000 0044 000c

// File: tests/tb_cluster_dma_frontend.sv
/*
 * Trace-driven testbench for the cluster DMA front end
 * Group models, value checker and watchdog
 */
`timescale 1ns/1ps

module tb_cluster_dma_frontend;

  localparam int NumGroups = cluster_cfg_pkg::DefNumGroups;

  logic                              clk_i;
  logic                              arst_n_i;
  dma_pkg::dma_req_t                 dma_req_i;
  logic                              dma_req_valid_i;
  logic                              dma_req_ready_o;
  dma_pkg::dma_req_t [NumGroups-1:0] group_req_o;
  logic              [NumGroups-1:0] group_req_valid_o;
  logic              [NumGroups-1:0] group_req_ready_i;
  logic              [NumGroups-1:0] group_done_i;
  dma_pkg::dma_meta_t                dma_meta_o;

  // Trace contents
  string             test_name[$];
  int                test_mode[$];
  dma_pkg::dma_req_t req_list[$];
  int                req_test[$];
  dma_pkg::dma_req_t exp_list[$];
  int                exp_group[$];
  int                exp_test[$];
  int                trace_lines = 0;
  bit                trace_loaded = 0;

  // Expected chunks of the running test, with their groups
  dma_pkg::dma_req_t batch_exp[$];
  int                batch_grp[$];
  int                cur_test = 0;
  bit                random_ready = 0;
  int                accepted = 0;
  int                complete_cnt = 0;
  int                errors = 0;
  int                pending_done[NumGroups];
  int                done_wait[NumGroups];

  cluster_dma_frontend dut_i (
    .clk_i            (clk_i            ),
    .arst_n_i         (arst_n_i         ),
    .dma_req_i        (dma_req_i        ),
    .dma_req_valid_i  (dma_req_valid_i  ),
    .dma_req_ready_o  (dma_req_ready_o  ),
    .group_req_o      (group_req_o      ),
    .group_req_valid_o(group_req_valid_o),
    .group_req_ready_i(group_req_ready_i),
    .group_done_i     (group_done_i     ),
    .dma_meta_o       (dma_meta_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  // Whitespace separated field of a trace line
  function automatic string token_at(string s, int idx);
    int  n;
    int  start;
    bit  in_tok;
    bit  sep;
    n      = 0;
    start  = 0;
    in_tok = 1'b0;
    for (int i = 0; i < s.len(); i++) begin
      sep = (s[i] == " ") || (s[i] == "\t") || (s[i] == "\n") || (s[i] == "\r");
      if (!sep && !in_tok) begin
        start  = i;
        in_tok = 1'b1;
      end else if (sep && in_tok) begin
        if (n == idx) return s.substr(start, i - 1);
        n++;
        in_tok = 1'b0;
      end
    end
    if (in_tok && n == idx) return s.substr(start, s.len() - 1);
    return "";
  endfunction

  function automatic dma_pkg::dma_req_t make_req(string s, int first);
    dma_pkg::dma_req_t r;
    r.src_addr  = token_at(s, first).atohex();
    r.dst_addr  = token_at(s, first + 1).atohex();
    r.num_bytes = token_at(s, first + 2).atohex();
    return r;
  endfunction

  task automatic load_trace(output bit ok);
    int    fd;
    string line;
    string kind;
    fd = $fopen("tests/dma_trace.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fgets(line, fd) != 0) begin
        kind = token_at(line, 0);
        if (kind == "T") begin
          test_name.push_back(token_at(line, 1));
          test_mode.push_back(token_at(line, 2).atoi());
        end else if (kind == "R") begin
          req_list.push_back(make_req(line, 1));
          req_test.push_back(test_name.size() - 1);
        end else if (kind == "C") begin
          exp_group.push_back(token_at(line, 1).atoi());
          exp_list.push_back(make_req(line, 2));
          exp_test.push_back(test_name.size() - 1);
        end
        if (kind == "T" || kind == "R" || kind == "C") trace_lines++;
      end
      $fclose(fd);
    end
  endtask

  // Per-group order is kept, so take the first pending entry of that group
  task automatic accept_chunk(int g, dma_pkg::dma_req_t chunk);
    int    idx;
    string name;
    idx  = -1;
    name = test_name[cur_test];
    for (int i = 0; i < batch_grp.size(); i++) begin
      if (batch_grp[i] == g && idx < 0) idx = i;
    end
    accepted++;
    check_value({name, " busy on accept"}, 1, dma_meta_o.busy);
    if (idx < 0) begin
      $display("Test %s: group %0d got a chunk that the trace does not list", name, g);
      errors++;
    end else begin
      check_value({name, " src"}, batch_exp[idx].src_addr, chunk.src_addr);
      check_value({name, " dst"}, batch_exp[idx].dst_addr, chunk.dst_addr);
      check_value({name, " len"}, batch_exp[idx].num_bytes, chunk.num_bytes);
      batch_exp.delete(idx);
      batch_grp.delete(idx);
    end
  endtask

  // Group models: accept, then report done after a random delay
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      for (int g = 0; g < NumGroups; g++) begin
        if (group_req_valid_o[g] && group_req_ready_i[g]) begin
          accept_chunk(g, group_req_o[g]);
          pending_done[g]++;
        end
      end
      if (dma_meta_o.trans_complete) complete_cnt++;
    end
    #1;
    for (int g = 0; g < NumGroups; g++) begin
      group_req_ready_i[g] = arst_n_i && (!random_ready || ($urandom % 3 != 0));
      if (arst_n_i && pending_done[g] > 0 && done_wait[g] == 0) begin
        group_done_i[g] = 1'b1;
        pending_done[g]--;
        done_wait[g] = $urandom % 5;
      end else begin
        group_done_i[g] = 1'b0;
        if (done_wait[g] > 0) done_wait[g]--;
      end
    end
  end

  task automatic drive_request(dma_pkg::dma_req_t req);
    dma_req_i       = req;
    dma_req_valid_i = 1'b1;
    do @(posedge clk_i); while (!dma_req_ready_o);
    #1;
    dma_req_valid_i = 1'b0;
  endtask

  task automatic run_test(int t);
    int total;
    batch_exp.delete();
    batch_grp.delete();
    for (int i = 0; i < exp_list.size(); i++) begin
      if (exp_test[i] == t) begin
        batch_exp.push_back(exp_list[i]);
        batch_grp.push_back(exp_group[i]);
      end
    end
    total        = batch_exp.size();
    cur_test     = t;
    random_ready = (test_mode[t] != 0);
    accepted     = 0;
    complete_cnt = 0;
    for (int i = 0; i < req_list.size(); i++) begin
      if (req_test[i] == t) drive_request(req_list[i]);
    end
    while (!(accepted == total && complete_cnt > 0)) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    #1;
    check_value({test_name[t], " chunk count"}, total, accepted);
    check_value({test_name[t], " complete pulses"}, 1, complete_cnt);
    check_value({test_name[t], " busy after drain"}, 0, dma_meta_o.busy);
  endtask

  initial begin
    bit ok;
    void'($urandom(32'h44d1_6d6c));
    arst_n_i          = 1'b0;
    dma_req_i         = '0;
    dma_req_valid_i   = 1'b0;
    group_req_ready_i = '0;
    group_done_i      = '0;
    for (int g = 0; g < NumGroups; g++) begin
      pending_done[g] = 0;
      done_wait[g]    = 0;
    end
    load_trace(ok);
    trace_loaded = 1'b1;
    if (!ok) begin
      $display("Could not open the trace file tests/dma_trace.txt");
      $display("Something failed");
      $finish;
    end else begin
      repeat (10) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      @(posedge clk_i);
      #1;
      check_value("reset req_ready", 1, dma_req_ready_o);
      check_value("reset group_valid", 0, group_req_valid_o);
      check_value("reset meta", 0, dma_meta_o);
      for (int t = 0; t < test_name.size(); t++) run_test(t);
      $display("Errors: %0d", errors);
      if (errors == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

  initial begin
    wait (trace_loaded);
    repeat (trace_lines * 200 + 1000) @(posedge clk_i);
    $display("Watchdog: the run did not finish within %0d cycles", trace_lines * 200 + 1000);
    $display("Something failed");
    $finish;
  end

endmodule : tb_cluster_dma_frontend
